// ==== Bender.yml ====
package:
  name: axilite_noc_bridge

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/noc_pkg.sv
      - hdl/axi_pkg.sv
      - hdl/req_if.sv
      - hdl/req_queue.sv
      - hdl/bridge_ctrl.sv
      - hdl/flit_builder.sv
      - hdl/resp_unpack.sv
      - hdl/axilite_noc_bridge.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/axilite_noc_bridge_assert.sv
      - verification/tb_axilite_noc_bridge.sv

// ==== compile.f ====
+incdir+hdl
hdl/noc_pkg.sv
hdl/axi_pkg.sv
hdl/req_if.sv
hdl/req_queue.sv
hdl/bridge_ctrl.sv
hdl/flit_builder.sv
hdl/resp_unpack.sv
hdl/axilite_noc_bridge.sv
verification/tb_clock.sv
verification/axilite_noc_bridge_assert.sv
verification/tb_axilite_noc_bridge.sv

// ==== hdl/axi_pkg.sv ====
`default_nettype none
`include "bridge_defines.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10
    } axi_resp_e;

    typedef enum logic {
        store = 1'b0,
        load  = 1'b1
    } req_kind_e;

    // one queued AXI-lite request
    typedef struct packed {
        req_kind_e                  kind;
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [`AXI_DATA_WIDTH-1:0] data;   // unused for loads
    } axi_req_t;

endpackage

`default_nettype wire

// ==== hdl/axilite_noc_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module axilite_noc_bridge (
    input  logic                         clk,
    input  logic                         rst,

    input  logic [`AXI_ADDR_WIDTH-1:0]   awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`AXI_DATA_WIDTH-1:0]   wdata,
    input  logic                         wvalid,
    output logic                         wready,
    input  logic [`AXI_ADDR_WIDTH-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [`AXI_DATA_WIDTH-1:0]   rdata,
    output axi_pkg::axi_resp_e           rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output axi_pkg::axi_resp_e           bresp,
    output logic                         bvalid,
    input  logic                         bready,

    output logic                         noc2_valid,
    output logic [`NOC_DATA_WIDTH-1:0]   noc2_data,
    input  logic                         noc2_ready,
    input  logic                         noc3_valid,
    input  logic [`NOC_DATA_WIDTH-1:0]   noc3_data,
    output logic                         noc3_ready,

    input  logic [`NOC_CHIPID_WIDTH-1:0] src_chipid,
    input  logic [`NOC_XY_WIDTH-1:0]     src_x,
    input  logic [`NOC_XY_WIDTH-1:0]     src_y,
    input  logic [`NOC_FBITS_WIDTH-1:0]  src_fbits,
    input  logic [`NOC_CHIPID_WIDTH-1:0] dst_chipid,
    input  logic [`NOC_XY_WIDTH-1:0]     dst_x,
    input  logic [`NOC_XY_WIDTH-1:0]     dst_y,
    input  logic [`NOC_FBITS_WIDTH-1:0]  dst_fbits
);
    import noc_pkg::*;
    import axi_pkg::*;

    req_if     req ();
    flit_sel_e flit_sel;
    noc_flit_u flit;

    assign rresp     = okay;    // no error path
    assign bresp     = okay;
    assign noc2_data = flit.raw;

    req_queue u_req_queue (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .req     (req.queue)
    );

    bridge_ctrl u_bridge_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req.ctrl),
        .flit_sel   (flit_sel),
        .noc2_valid (noc2_valid),
        .noc2_ready (noc2_ready),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    flit_builder u_flit_builder (
        .req        (req.view),
        .flit_sel   (flit_sel),
        .src_chipid (src_chipid),
        .src_x      (src_x),
        .src_y      (src_y),
        .src_fbits  (src_fbits),
        .dst_chipid (dst_chipid),
        .dst_x      (dst_x),
        .dst_y      (dst_y),
        .dst_fbits  (dst_fbits),
        .flit       (flit)
    );

    resp_unpack u_resp_unpack (
        .clk        (clk),
        .rst        (rst),
        .noc3_valid (noc3_valid),
        .noc3_data  (noc3_data),
        .noc3_ready (noc3_ready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready)
    );

endmodule

`default_nettype wire

// ==== hdl/bridge_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module bridge_ctrl (
    input  logic               clk,
    input  logic               rst,
    req_if.ctrl                req,
    output noc_pkg::flit_sel_e flit_sel,
    output logic               noc2_valid,
    input  logic               noc2_ready,
    output logic               bvalid,
    input  logic               bready
);
    import noc_pkg::*;
    import axi_pkg::*;

    localparam logic [1:0] LAST_HDR = 2'(`NOC_HDR_FLITS - 1);
    localparam logic [1:0] DATA_IDX = 2'(`NOC_HDR_FLITS);

    typedef enum logic {
        idle,
        sending
    } state_e;

    state_e     state;
    logic [1:0] cnt;        // index of flit on offer
    logic       start;
    logic       xfer;
    logic       last_flit;
    logic       store_done;

    // a store waits for the previous write response to be taken
    assign start      = req.valid && !(req.kind == store && bvalid);
    assign xfer       = noc2_valid && noc2_ready;
    assign last_flit  = (req.kind == store) ? (cnt == DATA_IDX) : (cnt == LAST_HDR);
    assign store_done = xfer && last_flit && (req.kind == store);

    assign noc2_valid = (state == sending);
    assign flit_sel   = flit_sel_e'(cnt);
    assign req.pop    = xfer && last_flit;     // head leaves with its last flit

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= sending;
                        cnt   <= '0;        // hdr0 first
                    end
                end
                sending: begin
                    if (xfer) begin
                        if (last_flit)
                            state <= idle;  // gap of one cycle at least
                        else
                            cnt <= cnt + 2'd1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // write response, held until bready
    always_ff @(posedge clk) begin
        if (rst)
            bvalid <= 1'b0;
        else if (store_done)
            bvalid <= 1'b1;
        else if (bready)
            bvalid <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== hdl/bridge_defines.svh ====
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// one NoC flit, one AXI-lite beat
`define NOC_DATA_WIDTH      64
`define AXI_ADDR_WIDTH      32
`define AXI_DATA_WIDTH      64

// request queue entries
`define REQ_DEPTH           4

// header flits ahead of any payload
`define NOC_HDR_FLITS       3

// NoC header field widths
`define NOC_CHIPID_WIDTH    14
`define NOC_XY_WIDTH        8
`define NOC_FBITS_WIDTH     4
`define NOC_ADDR_WIDTH      48

`endif

// ==== hdl/flit_builder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module flit_builder (
    req_if.view                         req,
    input  noc_pkg::flit_sel_e          flit_sel,
    input  logic [`NOC_CHIPID_WIDTH-1:0] src_chipid,
    input  logic [`NOC_XY_WIDTH-1:0]     src_x,
    input  logic [`NOC_XY_WIDTH-1:0]     src_y,
    input  logic [`NOC_FBITS_WIDTH-1:0]  src_fbits,
    input  logic [`NOC_CHIPID_WIDTH-1:0] dst_chipid,
    input  logic [`NOC_XY_WIDTH-1:0]     dst_x,
    input  logic [`NOC_XY_WIDTH-1:0]     dst_y,
    input  logic [`NOC_FBITS_WIDTH-1:0]  dst_fbits,
    output noc_pkg::noc_flit_u          flit
);
    import noc_pkg::*;
    import axi_pkg::*;

    noc_hdr0_t h0;
    noc_hdr1_t h1;
    noc_hdr2_t h2;

    always_comb begin
        h0            = '0;     // mshrid and options go out as zero
        h0.dst_chipid = dst_chipid;
        h0.dst_x      = dst_x;
        h0.dst_y      = dst_y;
        h0.dst_fbits  = dst_fbits;
        h0.length     = (req.kind == store) ? 8'(`NOC_HDR_FLITS) : 8'(`NOC_HDR_FLITS - 1);
        h0.msg_type   = (req.kind == store) ? nc_store_req : nc_load_req;

        h1            = '0;
        h1.addr       = {{(`NOC_ADDR_WIDTH - `AXI_ADDR_WIDTH){1'b0}}, req.addr};
        h1.data_size  = size_8b;

        h2            = '0;
        h2.src_chipid = src_chipid;
        h2.src_x      = src_x;
        h2.src_y      = src_y;
        h2.src_fbits  = src_fbits;
    end

    always_comb begin
        case (flit_sel)
            hdr0:    flit.hdr0 = h0;
            hdr1:    flit.raw  = h1;
            hdr2:    flit.raw  = h2;
            default: flit.raw  = req.data;  // store payload
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/noc_pkg.sv ====
`default_nettype none
`include "bridge_defines.svh"

package noc_pkg;

    typedef enum logic [7:0] {
        nc_load_req  = 8'd14,
        nc_store_req = 8'd15,
        nc_load_ack  = 8'd24
    } noc_msg_type_e;

    typedef enum logic [2:0] {
        size_8b = 3'd3  // only size in use
    } noc_data_size_e;

    typedef struct packed {
        logic [`NOC_CHIPID_WIDTH-1:0] dst_chipid;
        logic [`NOC_XY_WIDTH-1:0]     dst_x;
        logic [`NOC_XY_WIDTH-1:0]     dst_y;
        logic [`NOC_FBITS_WIDTH-1:0]  dst_fbits;
        logic [7:0]                   length;     // flits after this one
        noc_msg_type_e                msg_type;
        logic [7:0]                   mshrid;
        logic [5:0]                   options1;
    } noc_hdr0_t;

    typedef struct packed {
        logic [`NOC_ADDR_WIDTH-1:0]   addr;
        noc_data_size_e               data_size;
        logic [12:0]                  rsvd;
    } noc_hdr1_t;

    typedef struct packed {
        logic [`NOC_CHIPID_WIDTH-1:0] src_chipid;
        logic [`NOC_XY_WIDTH-1:0]     src_x;
        logic [`NOC_XY_WIDTH-1:0]     src_y;
        logic [`NOC_FBITS_WIDTH-1:0]  src_fbits;
        logic [29:0]                  rsvd;
    } noc_hdr2_t;

    // a flit is either a routing header or a plain data word
    typedef union packed {
        noc_hdr0_t                    hdr0;
        logic [`NOC_DATA_WIDTH-1:0]   raw;
    } noc_flit_u;

    typedef enum logic [1:0] {
        hdr0 = 2'd0,
        hdr1 = 2'd1,
        hdr2 = 2'd2,
        data = 2'd3
    } flit_sel_e;

endpackage

`default_nettype wire

// ==== hdl/req_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

interface req_if;
    import axi_pkg::*;

    logic                       valid;  // queue not empty
    req_kind_e                  kind;
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic                       pop;    // drop head at this edge

    modport queue (output valid, kind, addr, data, input pop);
    modport ctrl  (input valid, kind, output pop);
    modport view  (input kind, addr, data);

endinterface

`default_nettype wire

// ==== hdl/req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module req_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`AXI_DATA_WIDTH-1:0] wdata,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [`AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    req_if.queue                       req
);
    import axi_pkg::*;

    localparam int PTR_W = $clog2(`REQ_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(`REQ_DEPTH);

    axi_req_t         mem [`REQ_DEPTH];
    axi_req_t         push_req;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_nxt;
    logic             space;        // registered not-full flag
    logic             store_offer;
    logic             push;

    assign store_offer = awvalid && wvalid;     // needs both halves
    assign push        = (store_offer || arvalid) && space;

    // store wins over a load offered in the same cycle
    assign awready = store_offer && space;
    assign wready  = store_offer && space;
    assign arready = arvalid && !store_offer && space;

    always_comb begin
        push_req.kind = store_offer ? store : load;
        push_req.addr = store_offer ? awaddr : araddr;
        push_req.data = store_offer ? wdata : '0;
    end

    assign count_nxt = count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, req.pop};

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            space  <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (req.pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count_nxt;
            space <= (count_nxt != FULL_CNT);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_req;
    end

    // head of queue
    assign req.valid = (count != '0);
    assign req.kind  = mem[rd_ptr].kind;
    assign req.addr  = mem[rd_ptr].addr;
    assign req.data  = mem[rd_ptr].data;

endmodule

`default_nettype wire

// ==== hdl/resp_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module resp_unpack (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       noc3_valid,
    input  logic [`NOC_DATA_WIDTH-1:0] noc3_data,
    output logic                       noc3_ready,
    output logic [`AXI_DATA_WIDTH-1:0] rdata,
    output logic                       rvalid,
    input  logic                       rready
);
    import noc_pkg::*;

    noc_flit_u  in_flit;
    logic [7:0] remaining;      // flits left in current message
    logic       is_ack;         // current message is a load ack
    logic       at_hdr;
    logic       xfer;
    logic       last_flit;
    logic       ack_flit;

    assign in_flit.raw = noc3_data;

    // stall the NoC while a read beat is waiting
    assign noc3_ready = !rvalid;
    assign xfer       = noc3_valid && noc3_ready;
    assign at_hdr     = (remaining == 8'd0);

    assign last_flit = at_hdr ? (in_flit.hdr0.length == 8'd0) : (remaining == 8'd1);
    assign ack_flit  = at_hdr ? (in_flit.hdr0.msg_type == nc_load_ack) : is_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
            is_ack    <= 1'b0;
        end else if (xfer) begin
            if (at_hdr) begin
                remaining <= in_flit.hdr0.length;
                is_ack    <= (in_flit.hdr0.msg_type == nc_load_ack);
            end else begin
                remaining <= remaining - 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            rvalid <= 1'b0;
        else if (xfer && last_flit && ack_flit)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // other message types pass through without touching rdata
    always_ff @(posedge clk) begin
        if (xfer && last_flit && ack_flit)
            rdata <= in_flit.raw;
    end

endmodule

`default_nettype wire

// ==== verification/axilite_noc_bridge_assert.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module axilite_noc_bridge_assert (
    input logic                       clk,
    input logic                       rst,
    input logic                       noc2_valid,
    input logic                       noc2_ready,
    input logic [`NOC_DATA_WIDTH-1:0] noc2_data,
    input logic                       rvalid,
    input logic                       rready,
    input logic [`AXI_DATA_WIDTH-1:0] rdata,
    input logic                       bvalid,
    input logic                       bready
);
    // flit stays put while the NoC stalls
    noc2_hold: assert property (@(posedge clk) disable iff (rst)
        noc2_valid && !noc2_ready |=> noc2_valid && $stable(noc2_data))
        else $error("noc2 flit changed or dropped under back-pressure");

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read beat changed or dropped before rready");

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("write response dropped before bready");

    // outputs settle one edge into reset
    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !noc2_valid && !rvalid && !bvalid)
        else $error("valid output high during reset");
endmodule

`default_nettype wire

// ==== verification/tb_axilite_noc_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module tb_axilite_noc_bridge;
    import noc_pkg::*;
    import axi_pkg::*;

    localparam int NUM_TESTS   = 5;
    localparam int CYCLE_LIMIT = 200 * NUM_TESTS;

    logic                         clk;
    logic                         rst;
    logic [`AXI_ADDR_WIDTH-1:0]   awaddr;
    logic [`AXI_ADDR_WIDTH-1:0]   araddr;
    logic [`AXI_DATA_WIDTH-1:0]   wdata;
    logic [`AXI_DATA_WIDTH-1:0]   rdata;
    logic                         awvalid, awready, wvalid, wready, arvalid, arready;
    logic                         rvalid, rready, bvalid, bready;
    axi_resp_e                    rresp;
    axi_resp_e                    bresp;
    logic                         noc2_valid, noc2_ready, noc3_valid, noc3_ready;
    logic [`NOC_DATA_WIDTH-1:0]   noc2_data;
    logic [`NOC_DATA_WIDTH-1:0]   noc3_data;
    logic [`NOC_CHIPID_WIDTH-1:0] src_chipid, dst_chipid;
    logic [`NOC_XY_WIDTH-1:0]     src_x, src_y, dst_x, dst_y;
    logic [`NOC_FBITS_WIDTH-1:0]  src_fbits, dst_fbits;

    noc_flit_u   got_flits[$];
    noc_flit_u   exp_flits[$];
    logic [31:0] lfsr;
    int          b_count = 0;
    int          r_count = 0;
    int          cycles = 0;
    int          errors = 0;
    int          tests_failed = 0;

    tb_clock u_clock (.clk(clk), .rst(rst));

    axilite_noc_bridge DUT (.*);

    bind axilite_noc_bridge axilite_noc_bridge_assert u_assert (
        .clk(clk), .rst(rst), .noc2_valid(noc2_valid), .noc2_ready(noc2_ready),
        .noc2_data(noc2_data), .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .bvalid(bvalid), .bready(bready)
    );

    // sampled mid-cycle, so a transfer seen here lands at the next edge
    always @(negedge clk) begin
        if (!rst && noc2_valid && noc2_ready)
            got_flits.push_back(noc2_data);
        if (!rst && bvalid && bready)
            b_count++;
        if (!rst && rvalid && rready)
            r_count++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h80200003;  // galois taps 32,22,2,1
        return b;
    endfunction

    function automatic logic [63:0] rand_word();
        logic [63:0] w;
        for (int i = 0; i < 64; i++)
            w[i] = rand_bit();
        return w;
    endfunction

    task automatic flit_eq(input noc_flit_u got, input noc_flit_u exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s flit %h, expected %h", $time, what, got.raw, exp.raw);
            errors++;
        end
    endtask

    task automatic data_eq(input logic [`AXI_DATA_WIDTH-1:0] got,
                           input logic [`AXI_DATA_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic resp_eq(input axi_resp_e got, input axi_resp_e exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %s", $time, what, got, exp.name());
            errors++;
        end
    endtask

    task automatic flag_eq(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic count_eq(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // flits a request must turn into, in order
    task automatic expect_msg(input req_kind_e kind, input logic [31:0] addr,
                              input logic [63:0] d);
        noc_flit_u f;
        noc_hdr1_t h1;
        noc_hdr2_t h2;
        f = '0;
        f.hdr0.dst_chipid = dst_chipid;
        f.hdr0.dst_x      = dst_x;
        f.hdr0.dst_y      = dst_y;
        f.hdr0.dst_fbits  = dst_fbits;
        f.hdr0.length     = (kind == store) ? 8'd3 : 8'd2;
        f.hdr0.msg_type   = (kind == store) ? nc_store_req : nc_load_req;
        exp_flits.push_back(f);
        h1 = '0;
        h1.addr = {16'h0000, addr};
        h1.data_size = size_8b;
        f.raw = h1;
        exp_flits.push_back(f);
        h2 = {src_chipid, src_x, src_y, src_fbits, 30'd0};
        f.raw = h2;
        exp_flits.push_back(f);
        if (kind == store) begin
            f.raw = d;
            exp_flits.push_back(f);
        end
    endtask

    task automatic wait_accept(input logic is_store);
        logic ok;
        do begin
            @(negedge clk);
            ok = is_store ? (awready && wready) : arready;
            next_cycle();
        end while (!ok);
        awvalid = is_store ? 1'b0 : awvalid;
        wvalid  = is_store ? 1'b0 : wvalid;
        arvalid = is_store ? arvalid : 1'b0;
    endtask

    task automatic issue_store(input logic [31:0] addr, input logic [63:0] d);
        awaddr  = addr;
        wdata   = d;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        wait_accept(1'b1);
    endtask

    task automatic issue_load(input logic [31:0] addr);
        araddr  = addr;
        arvalid = 1'b1;
        wait_accept(1'b0);
    endtask

    task automatic send_noc3(input logic [63:0] w);
        logic ok;
        noc3_valid = 1'b1;
        noc3_data  = w;
        do begin
            @(negedge clk);
            ok = noc3_ready;
            next_cycle();
        end while (!ok);
        noc3_valid = 1'b0;
    endtask

    task automatic wait_flits();
        while (got_flits.size() < exp_flits.size())
            next_cycle();
        repeat (4) next_cycle();    // room for a stray extra flit
    endtask

    task automatic flits_in_order(input string what);
        count_eq(got_flits.size(), exp_flits.size(), {what, " flit count"});
        while (got_flits.size() > 0 && exp_flits.size() > 0)
            flit_eq(got_flits.pop_front(), exp_flits.pop_front(), what);
        got_flits.delete();
        exp_flits.delete();
    endtask

    task automatic take_write_resp();
        @(negedge clk);
        while (!bvalid)
            @(negedge clk);
        resp_eq(bresp, okay, "bresp");
        next_cycle();
        bready = 1'b1;
        next_cycle();
        bready = 1'b0;
    endtask

    // holds rready low for a while before taking the beat
    task automatic take_read(input logic [63:0] exp, input int hold);
        @(negedge clk);
        while (!rvalid)
            @(negedge clk);
        repeat (hold) begin
            data_eq(rdata, exp, "rdata while stalled");
            @(negedge clk);
            flag_eq(rvalid, 1'b1, "rvalid while stalled");
            flag_eq(noc3_ready, 1'b0, "noc3_ready while read pending");
        end
        data_eq(rdata, exp, "rdata");
        resp_eq(rresp, okay, "rresp");
        next_cycle();
        rready = 1'b1;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic single_store();
        logic [63:0] d;
        int          b0;
        d  = rand_word();
        b0 = b_count;
        noc2_ready = 1'b1;
        expect_msg(store, 32'h0000_1000, d);
        issue_store(32'h0000_1000, d);
        take_write_resp();
        repeat (4) next_cycle();
        flits_in_order("single store");
        count_eq(b_count - b0, 1, "write responses");
    endtask

    task automatic single_load();
        noc_flit_u   h;
        logic [63:0] d;
        int          r0;
        d  = rand_word();
        r0 = r_count;
        expect_msg(load, 32'h0000_2040, '0);
        issue_load(32'h0000_2040);
        wait_flits();
        flits_in_order("single load");
        h = '0;
        h.hdr0.msg_type = nc_load_ack;
        h.hdr0.length   = 8'd1;
        send_noc3(h.raw);
        send_noc3(d);
        take_read(d, 0);
        count_eq(r_count - r0, 1, "read beats");
    endtask

    task automatic ready_toggling();
        logic [63:0] d;
        int          b0;
        d  = rand_word();
        b0 = b_count;
        noc2_ready = 1'b0;
        bready     = 1'b1;
        expect_msg(store, 32'h0000_3008, d);
        expect_msg(load, 32'h0000_3010, '0);
        issue_store(32'h0000_3008, d);
        issue_load(32'h0000_3010);
        while (got_flits.size() < exp_flits.size()) begin
            noc2_ready = rand_bit();
            next_cycle();
        end
        noc2_ready = 1'b1;
        repeat (4) next_cycle();
        flits_in_order("toggled ready");
        count_eq(b_count - b0, 1, "write responses");
        bready = 1'b0;
    endtask

    task automatic mixed_queue();
        logic [63:0] d0, d1, d2;
        int          b0;
        d0 = rand_word();
        d1 = rand_word();
        d2 = rand_word();
        b0 = b_count;
        noc2_ready = 1'b0;          // keep everything queued
        bready     = 1'b1;
        expect_msg(store, 32'h0000_4000, d0);
        expect_msg(store, 32'h0000_4008, d1);
        expect_msg(load, 32'h0000_4100, '0);
        expect_msg(load, 32'h0000_4108, '0);
        expect_msg(store, 32'h0000_4010, d2);
        issue_store(32'h0000_4000, d0);
        awaddr  = 32'h0000_4008;
        wdata   = d1;
        araddr  = 32'h0000_4100;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        arvalid = 1'b1;
        @(negedge clk);
        flag_eq(awready, 1'b1, "awready with store and load offered");
        flag_eq(arready, 1'b0, "arready with store and load offered");
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_accept(1'b0);
        issue_load(32'h0000_4108);
        awaddr  = 32'h0000_4010;
        wdata   = d2;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        repeat (3) begin
            @(negedge clk);
            flag_eq(awready, 1'b0, "awready with queue full");
            flag_eq(wready, 1'b0, "wready with queue full");
            next_cycle();
        end
        noc2_ready = 1'b1;
        wait_accept(1'b1);
        wait_flits();
        flits_in_order("mixed queue");
        count_eq(b_count - b0, 3, "write responses");
        bready = 1'b0;
    endtask

    task automatic discard_then_ack();
        noc_flit_u   h;
        logic [63:0] d;
        int          r0;
        r0 = r_count;
        h  = '0;
        h.hdr0.msg_type = nc_store_req;     // not a load ack
        h.hdr0.length   = 8'd2;
        send_noc3(h.raw);
        send_noc3(rand_word());
        send_noc3(rand_word());
        repeat (6) begin
            @(negedge clk);
            flag_eq(rvalid, 1'b0, "rvalid after foreign message");
            next_cycle();
        end
        d = rand_word();
        h.hdr0.msg_type = nc_load_ack;
        h.hdr0.length   = 8'd1;
        send_noc3(h.raw);
        send_noc3(d);
        take_read(d, 6);
        count_eq(r_count - r0, 1, "read beats");
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("test %-18s ok", name);
        end else begin
            $display("test %-18s failed, %0d error(s)", name, errors - err0);
            tests_failed++;
        end
    endtask

    initial begin
        int e0;
        lfsr       = 32'h04fe3d04;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        bready     = 1'b0;
        noc2_ready = 1'b0;
        noc3_valid = 1'b0;
        noc3_data  = '0;
        src_chipid = 14'h0123;
        src_x      = 8'h02;
        src_y      = 8'h05;
        src_fbits  = 4'ha;
        dst_chipid = 14'h3abc;
        dst_x      = 8'h11;
        dst_y      = 8'h22;
        dst_fbits  = 4'h5;
        wait (rst === 1'b0);
        next_cycle();
        e0 = errors;
        single_store();
        report_test("single store", e0);
        e0 = errors;
        single_load();
        report_test("single load", e0);
        e0 = errors;
        ready_toggling();
        report_test("toggled ready", e0);
        e0 = errors;
        mixed_queue();
        report_test("mixed queue", e0);
        e0 = errors;
        discard_then_ack();
        report_test("discard then ack", e0);
        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;      // released just after an edge
    end
endmodule

`default_nettype wire
